// ==== dv/asp_top_tb.sv ====
`timescale 1ns/100ps
`include "asp_settings.svh"
// Testbench for the copy shell with host and local memory models
// Applies a descriptor table in a loop, then checks APB decode

module asp_top_tb;

    localparam int ROWS    = 6;
    localparam int TIMEOUT = 2000;

    logic                             pclk;
    logic                             rst;
    logic [`ASP_APB_ADDR_W-1:0]       paddr;
    logic                             psel;
    logic                             penable;
    logic                             pwrite;
    logic [`ASP_DATA_W-1:0]           pwdata;
    logic [`ASP_DATA_W-1:0]           prdata;
    logic                             pready;
    logic                             pslverr;
    mem_chan_pkg::host_addr_t         host_address;
    logic                             host_read;
    logic                             host_waitrequest   = 1'b0;
    mem_chan_pkg::mem_word_t          host_readdata      = '0;
    logic                             host_readdatavalid = 1'b0;
    mem_chan_pkg::lmem_addr_t         lmem_address;
    logic                             lmem_write;
    mem_chan_pkg::mem_word_t          lmem_writedata;
    logic                             lmem_waitrequest   = 1'b0;
    logic                             job_done;

    // ====================================================================
    // Descriptor table with one job per row
    // ====================================================================
    string                     name_tab [ROWS] = '{"copy_len1", "copy_len5", "copy_len40",
                                                   "backpressure", "zero_length", "start_busy"};
    mem_chan_pkg::host_addr_t  src_tab  [ROWS] = '{24'h000100, 24'h001234, 24'h00abcd,
                                                   24'h7ffff0, 24'h000300, 24'h0c0000};
    // Backpressure row also wraps the local address space
    mem_chan_pkg::lmem_addr_t  dst_tab  [ROWS] = '{24'h000010, 24'h000200, 24'h000400,
                                                   24'hfffff0, 24'h000800, 24'h001000};
    mmio_csr_pkg::csr_len_t    len_tab  [ROWS] = '{16'd1, 16'd5, 16'd40, 16'd33, 16'd0, 16'd24};
    logic                      heavy_tab[ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
    logic                      clr_tab  [ROWS] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    logic                      busy_tab [ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    logic                      err_tab  [ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
    mmio_csr_pkg::done_cnt_t   done_tab [ROWS] = '{16'd1, 16'd2, 16'd3, 16'd4, 16'd4, 16'd1};

    // Model state
    logic                      heavy    = 1'b0;
    logic [31:0]               wait_rng = 32'd7;
    logic [31:0]               lat_rng  = 32'd7;
    int                        cyc      = 0;
    int                        due      = 0;
    int                        last_due = 0;
    int                        ret_idx  = 0;
    int                        wr_seen  = 0;
    int                        done_seen = 0;
    mem_chan_pkg::host_addr_t  pend_addr[$];
    int                        pend_due[$];
    mem_chan_pkg::lmem_addr_t  wr_addr_q[$];
    mem_chan_pkg::mem_word_t   wr_data_q[$];

    asp_top u_asp_top (.*);

    initial begin
        pclk = 1'b0;
        forever #2 pclk = ~pclk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Host memory content as a hash of the word address
    function automatic mem_chan_pkg::mem_word_t host_word(input mem_chan_pkg::host_addr_t a);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = xorshift32({8'h00, a} ^ 32'd7);
        hi = xorshift32(lo ^ {a, 8'h07});
        return {hi, lo};
    endfunction

    // ====================================================================
    // Memory models
    // ====================================================================
    // Sample accepted reads, local writes and completions
    always @(posedge pclk) begin
        cyc = cyc + 1;
        if (!rst && host_read && !host_waitrequest) begin
            lat_rng = xorshift32(lat_rng);
            due = cyc + int'(lat_rng % 32'd6);
            // Returns stay in order with at most one word per cycle
            if (due <= last_due) due = last_due + 1;
            last_due = due;
            pend_addr.push_back(host_address);
            pend_due.push_back(due);
        end
        if (!rst && lmem_write && !lmem_waitrequest) begin
            wr_addr_q.push_back(lmem_address);
            wr_data_q.push_back(lmem_writedata);
            wr_seen = wr_seen + 1;
        end
        if (!rst && job_done) done_seen = done_seen + 1;
    end

    // Drive stalls and returned data on the falling edge
    always @(negedge pclk) begin
        wait_rng = xorshift32(wait_rng);
        // Heavy mode stalls three cycles in four and light mode one in four
        host_waitrequest = heavy ? (wait_rng[1:0] != 2'd0) : (wait_rng[1:0] == 2'd0);
        lmem_waitrequest = heavy ? (wait_rng[9:8] != 2'd0) : (wait_rng[9:8] == 2'd0);
        if (ret_idx < pend_due.size() && pend_due[ret_idx] <= cyc) begin
            host_readdatavalid = 1'b1;
            host_readdata      = host_word(pend_addr[ret_idx]);
            ret_idx            = ret_idx + 1;
        end else begin
            host_readdatavalid = 1'b0;
            host_readdata      = '0;
        end
    end

    // ====================================================================
    // Checks and bus tasks
    // ====================================================================
    task automatic stop_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input mem_chan_pkg::mem_word_t exp,
                              input mem_chan_pkg::mem_word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input mem_chan_pkg::lmem_addr_t exp,
                              input mem_chan_pkg::lmem_addr_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_status(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
            stop_run();
        end
    endtask

    // Setup phase, then a single access phase with no wait states
    task automatic apb_access(input logic wr, input logic [`ASP_APB_ADDR_W-1:0] addr,
                              input logic [63:0] wdata, output logic [63:0] rdata,
                              output logic err);
        @(negedge pclk);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge pclk);
        penable = 1'b1;
        @(posedge pclk);
        check_flag($sformatf("pready at offset %h", addr), 1'b1, pready);
        rdata = prdata;
        err   = pslverr;
        @(negedge pclk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Selector 0 counts local writes and 1 counts job_done pulses
    task automatic wait_for(input int which, input int target, input string what);
        int waited;
        int seen;
        waited = 0;
        seen   = (which == 0) ? wr_seen : done_seen;
        while (seen < target) begin
            if (waited >= TIMEOUT) begin
                $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
                stop_run();
            end
            @(negedge pclk);
            waited++;
            seen = (which == 0) ? wr_seen : done_seen;
        end
    endtask

    // ====================================================================
    // One table row programs and launches a job, then checks status and data
    // ====================================================================
    task automatic run_row(input int i);
        mmio_csr_pkg::csr_word_u w;
        logic [63:0]             rdata;
        logic                    err;
        int                      base_wr;
        int                      base_done;
        heavy = heavy_tab[i];
        if (clr_tab[i]) begin
            w = '0;
            w.ctrl.clr = 1'b1;
            apb_access(1'b1, `ASP_CSR_CTRL, w, rdata, err);
            check_flag({name_tab[i], " clear pslverr"}, 1'b0, err);
        end
        base_wr   = wr_seen;
        base_done = done_seen;
        w.desc.src = src_tab[i];
        w.desc.dst = dst_tab[i];
        w.desc.len = len_tab[i];
        apb_access(1'b1, `ASP_CSR_DESC, w, rdata, err);
        check_flag({name_tab[i], " desc pslverr"}, 1'b0, err);
        w = '0;
        w.ctrl.start = 1'b1;
        apb_access(1'b1, `ASP_CSR_CTRL, w, rdata, err);
        check_flag({name_tab[i], " start pslverr"}, 1'b0, err);
        // Second start lands mid-job
        if (busy_tab[i]) begin
            wait_for(0, base_wr + 2, "the second local write of the job");
            apb_access(1'b1, `ASP_CSR_CTRL, w, rdata, err);
            check_flag({name_tab[i], " busy start pslverr"}, 1'b0, err);
        end
        if (len_tab[i] == '0) begin
            // Nothing may start within a short idle window
            repeat (20) @(negedge pclk);
        end else begin
            wait_for(1, base_done + 1, "the job_done pulse");
        end
        apb_access(1'b0, `ASP_CSR_STATUS, '0, rdata, err);
        check_flag({name_tab[i], " status pslverr"}, 1'b0, err);
        // Busy in bit 0 and error in bit 1 with the done count in 31:16
        check_status({name_tab[i], " status"}, {32'b0, done_tab[i], 14'b0, err_tab[i], 1'b0},
                     rdata);
        check_count({name_tab[i], " job_done pulses"}, (len_tab[i] == '0) ? 0 : 1,
                    done_seen - base_done);
        check_count({name_tab[i], " write count"}, int'(len_tab[i]), wr_seen - base_wr);
        for (int n = 0; n < int'(len_tab[i]); n++) begin
            check_addr($sformatf("%s address %0d", name_tab[i], n),
                       mem_chan_pkg::lmem_addr_t'(dst_tab[i] + n), wr_addr_q[base_wr + n]);
            check_word($sformatf("%s data %0d", name_tab[i], n),
                       host_word(mem_chan_pkg::host_addr_t'(src_tab[i] + n)),
                       wr_data_q[base_wr + n]);
        end
    endtask

    // Unknown offset and status write errors, then clear-status
    task automatic check_decode();
        mmio_csr_pkg::csr_word_u w;
        logic [63:0]             rdata;
        logic                    err;
        apb_access(1'b0, 8'h18, '0, rdata, err);
        check_flag("unknown offset pslverr", 1'b1, err);
        apb_access(1'b1, `ASP_CSR_STATUS, 64'h3, rdata, err);
        check_flag("status write pslverr", 1'b1, err);
        w = '0;
        w.ctrl.clr = 1'b1;
        apb_access(1'b1, `ASP_CSR_CTRL, w, rdata, err);
        check_flag("clear pslverr", 1'b0, err);
        apb_access(1'b0, `ASP_CSR_STATUS, '0, rdata, err);
        check_status("status after clear", 64'h0, rdata);
    endtask

    initial begin
        rst     = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        repeat (16) @(negedge pclk);
        rst = 1'b0;
        for (int i = 0; i < ROWS; i++) begin
            run_row(i);
        end
        check_decode();
        $display("No errors");
        $finish;
    end

endmodule

// ==== include/asp_settings.svh ====
// Build-wide widths, depths and CSR offsets for the copy shell
// Included by the packages and by any module that needs a raw width
`ifndef ASP_SETTINGS_SVH
`define ASP_SETTINGS_SVH

// MMIO and memory word width in bits
`define ASP_DATA_W       64
// Word addresses on the host and local memory ports
`define ASP_HOST_ADDR_W  24
`define ASP_LMEM_ADDR_W  24
// Job length field, in words
`define ASP_LEN_W        16
// Beat buffer slots, power of two, 4 or more
`define ASP_FIFO_DEPTH   8

// APB byte address width and register offsets
`define ASP_APB_ADDR_W   8
`define ASP_CSR_DESC     8'h00
`define ASP_CSR_CTRL     8'h08
`define ASP_CSR_STATUS   8'h10

`endif

// ==== logic/asp_top.sv ====
`timescale 1ns/100ps
`include "asp_settings.svh"
// Copy shell top level; APB registers, host read engine, beat buffer
// and local memory writer behind plain platform ports

module asp_top (
    input  logic                          pclk,
    input  logic                          rst,
    // APB slave
    input  logic [`ASP_APB_ADDR_W-1:0]    paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [`ASP_DATA_W-1:0]        pwdata,
    output logic [`ASP_DATA_W-1:0]        prdata,
    output logic                          pready,
    output logic                          pslverr,
    // Host read port
    output mem_chan_pkg::host_addr_t      host_address,
    output logic                          host_read,
    input  logic                          host_waitrequest,
    input  mem_chan_pkg::mem_word_t       host_readdata,
    input  logic                          host_readdatavalid,
    // Local memory write port
    output mem_chan_pkg::lmem_addr_t      lmem_address,
    output logic                          lmem_write,
    output mem_chan_pkg::mem_word_t       lmem_writedata,
    input  logic                          lmem_waitrequest,
    output logic                          job_done
);
    mem_chan_pkg::host_addr_t src_addr;
    mem_chan_pkg::lmem_addr_t dst_addr;
    mmio_csr_pkg::csr_len_t   length;
    logic                     start;
    logic                     done;

    // Engine to buffer, then buffer to writer
    beat_if rd_beats ();
    beat_if wr_beats ();

    mmio_csr_block u_csr (
        .pclk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata, .done,
        .prdata, .pready, .pslverr, .start, .src_addr, .dst_addr, .length, .job_done
    );

    host_read_engine u_reader (
        .pclk, .rst, .start, .src_addr, .length,
        .host_waitrequest, .host_readdata, .host_readdatavalid,
        .host_address, .host_read, .beats(rd_beats)
    );

    beat_fifo u_fifo (.pclk, .rst, .in_beats(rd_beats), .out_beats(wr_beats));

    local_mem_writer u_writer (
        .pclk, .rst, .start, .dst_addr, .lmem_waitrequest,
        .lmem_address, .lmem_write, .lmem_writedata, .done, .beats(wr_beats)
    );

endmodule

// ==== logic/beat_fifo.sv ====
`timescale 1ns/100ps
`include "asp_settings.svh"
// Beat buffer between host reads and local writes that absorbs read latency
// and reports free slots upstream as read credit

module beat_fifo (
    input  logic pclk,
    input  logic rst,
    beat_if.dst  in_beats,
    beat_if.src  out_beats
);
    localparam int PTR_W = $clog2(`ASP_FIFO_DEPTH);
    localparam mem_chan_pkg::slot_cnt_t DEPTH = `ASP_FIFO_DEPTH;

    mem_chan_pkg::mem_word_t data_mem [`ASP_FIFO_DEPTH];
    logic                    last_mem [`ASP_FIFO_DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    mem_chan_pkg::slot_cnt_t count;
    logic                    push;
    logic                    pop;

    // Upstream side
    assign in_beats.ready      = (count != DEPTH);
    assign in_beats.free_slots = DEPTH - count;
    assign push                = in_beats.valid && in_beats.ready;

    // Head of queue to the writer
    assign out_beats.valid = (count != '0);
    assign out_beats.data  = data_mem[rd_ptr];
    assign out_beats.last  = last_mem[rd_ptr];
    assign pop             = out_beats.valid && out_beats.ready;

    // Storage
    always_ff @(posedge pclk) begin
        if (push) begin
            data_mem[wr_ptr] <= in_beats.data;
            last_mem[wr_ptr] <= in_beats.last;
        end
    end

    // Pointers wrap on their own with a power-of-two depth
    always_ff @(posedge pclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + push - pop;
        end
    end

    // Producer credit never lets a beat arrive at a full buffer
    a_no_overflow: assert property (@(posedge pclk) disable iff (rst)
        in_beats.valid |-> count != DEPTH)
        else $error("beat offered to a full buffer");

    // A pop from empty would wrap the count past the depth and split it from the pointers
    a_no_underflow: assert property (@(posedge pclk) disable iff (rst)
        count <= DEPTH && count[PTR_W-1:0] == wr_ptr - rd_ptr)
        else $error("buffer occupancy out of range");

endmodule

// ==== logic/beat_if.sv ====
`timescale 1ns/100ps
// Read-data beat stream with valid/ready handshake and a free-slot credit
// One instance feeds the buffer, a second one drains it

interface beat_if;

    // Source side
    logic                    valid;
    mem_chan_pkg::mem_word_t data;
    logic                    last;

    // Receiver side
    logic                    ready;
    // Room the receiver still has, used as read credit upstream
    mem_chan_pkg::slot_cnt_t free_slots;

    modport src (
        output valid,
        output data,
        output last,
        input  ready,
        input  free_slots
    );

    modport dst (
        input  valid,
        input  data,
        input  last,
        output ready,
        output free_slots
    );

endinterface

// ==== logic/host_read_engine.sv ====
`timescale 1ns/100ps
// Host read producer; walks the source block and issues reads only while
// the beat buffer has a free slot for every read still in flight

module host_read_engine (
    input  logic                     pclk,
    input  logic                     rst,
    input  logic                     start,
    input  mem_chan_pkg::host_addr_t src_addr,
    input  mmio_csr_pkg::csr_len_t   length,
    input  logic                     host_waitrequest,
    input  mem_chan_pkg::mem_word_t  host_readdata,
    input  logic                     host_readdatavalid,
    output mem_chan_pkg::host_addr_t host_address,
    output logic                     host_read,
    beat_if.src                      beats
);
    mmio_csr_pkg::csr_len_t   len_q;
    mmio_csr_pkg::csr_len_t   issue_cnt;
    mmio_csr_pkg::csr_len_t   ret_cnt;
    mem_chan_pkg::slot_cnt_t  inflight;
    mem_chan_pkg::host_addr_t addr_q;
    logic                     active;
    logic                     rd_accept;
    logic                     beat_ret;

    // Credit rule: in-flight reads stay below the buffer's free slots
    assign host_read    = active && (issue_cnt != len_q) && (inflight < beats.free_slots);
    assign host_address = addr_q;
    assign rd_accept    = host_read && !host_waitrequest;
    assign beat_ret     = active && host_readdatavalid;

    // Returned words go straight into the buffer
    assign beats.valid = beat_ret;
    assign beats.data  = host_readdata;
    assign beats.last  = (ret_cnt == len_q - mmio_csr_pkg::csr_len_t'(1));

    always_ff @(posedge pclk) begin
        if (rst) begin
            active    <= 1'b0;
            len_q     <= '0;
            issue_cnt <= '0;
            ret_cnt   <= '0;
            inflight  <= '0;
            addr_q    <= '0;
        end else begin
            if (start) begin
                active    <= 1'b1;
                len_q     <= length;
                issue_cnt <= '0;
                ret_cnt   <= '0;
                addr_q    <= src_addr;
            end else begin
                if (rd_accept) begin
                    issue_cnt <= issue_cnt + 1'b1;
                    addr_q    <= addr_q + 1'b1;
                end
                // Job ends here once the final beat is pushed
                if (beat_ret) begin
                    ret_cnt <= ret_cnt + 1'b1;
                    if (beats.last) begin
                        active <= 1'b0;
                    end
                end
            end
            // Accept and return in one cycle cancel out
            case ({rd_accept, beat_ret})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: inflight <= inflight;
            endcase
        end
    end

    // A stalled read holds its request and address
    a_read_held: assert property (@(posedge pclk) disable iff (rst)
        host_read && host_waitrequest |=> host_read && $stable(host_address))
        else $error("host read changed under waitrequest");

    // Credit keeps the buffer ready for every returned word
    a_push_ready: assert property (@(posedge pclk) disable iff (rst)
        beats.valid |-> beats.ready)
        else $error("returned beat pushed into a full buffer");

endmodule

// ==== logic/local_mem_writer.sv ====
`timescale 1ns/100ps
// Local memory consumer; pops beats into a holding register and writes them
// to sequential addresses, holding each write through waitrequest

module local_mem_writer (
    input  logic                     pclk,
    input  logic                     rst,
    input  logic                     start,
    input  mem_chan_pkg::lmem_addr_t dst_addr,
    input  logic                     lmem_waitrequest,
    output mem_chan_pkg::lmem_addr_t lmem_address,
    output logic                     lmem_write,
    output mem_chan_pkg::mem_word_t  lmem_writedata,
    output logic                     done,
    beat_if.dst                      beats
);
    mem_chan_pkg::lmem_addr_t addr_q;
    mem_chan_pkg::mem_word_t  hold_data;
    logic                     hold_valid;
    logic                     hold_last;
    logic                     wr_accept;

    assign wr_accept = hold_valid && !lmem_waitrequest;

    // Holding slot is free when empty or emptying this cycle
    assign beats.free_slots = (!hold_valid || wr_accept) ? mem_chan_pkg::slot_cnt_t'(1) : '0;
    assign beats.ready      = (beats.free_slots != '0);

    assign lmem_write     = hold_valid;
    assign lmem_address   = addr_q;
    assign lmem_writedata = hold_data;

    // Last word of the job taken by local memory
    assign done = wr_accept && hold_last;

    // Holding register payload
    always_ff @(posedge pclk) begin
        if (beats.valid && beats.ready) begin
            hold_data <= beats.data;
            hold_last <= beats.last;
        end
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            hold_valid <= 1'b0;
            addr_q     <= '0;
        end else begin
            if (beats.valid && beats.ready) hold_valid <= 1'b1;
            else if (wr_accept)             hold_valid <= 1'b0;
            // Address steps only on an accepted write
            if (start)          addr_q <= dst_addr;
            else if (wr_accept) addr_q <= addr_q + 1'b1;
        end
    end

endmodule

// ==== logic/mem_chan_pkg.sv ====
// Memory channel types shared by the host read and local write paths
// Also sizes the free-slot credit count of the beat buffer
`include "asp_settings.svh"

package mem_chan_pkg;

    // One data word on either memory port
    typedef logic [`ASP_DATA_W-1:0] mem_word_t;

    // Word addresses
    typedef logic [`ASP_HOST_ADDR_W-1:0] host_addr_t;
    typedef logic [`ASP_LMEM_ADDR_W-1:0] lmem_addr_t;

    // Holds 0 up to the full depth, hence the extra bit
    typedef logic [$clog2(`ASP_FIFO_DEPTH):0] slot_cnt_t;

endpackage

// ==== logic/mmio_csr_block.sv ====
`timescale 1ns/100ps
`include "asp_settings.svh"
// APB register block; holds the copy descriptor, launches jobs and
// keeps busy, error and the done count for status reads

module mmio_csr_block (
    input  logic                          pclk,
    input  logic                          rst,
    input  logic [`ASP_APB_ADDR_W-1:0]    paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [`ASP_DATA_W-1:0]        pwdata,
    input  logic                          done,
    output logic [`ASP_DATA_W-1:0]        prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic                          start,
    output mem_chan_pkg::host_addr_t      src_addr,
    output mem_chan_pkg::lmem_addr_t      dst_addr,
    output mmio_csr_pkg::csr_len_t        length,
    output logic                          job_done
);
    mmio_csr_pkg::csr_word_u wr_word;
    mmio_csr_pkg::csr_word_u desc_word;
    mmio_csr_pkg::done_cnt_t done_cnt;
    logic                    busy;
    logic                    error;
    logic                    access;
    logic                    hit_desc;
    logic                    hit_ctrl;
    logic                    hit_status;
    logic                    wr_desc;
    logic                    wr_ctrl;

    // ====================================================================
    // Decode
    // ====================================================================
    assign wr_word    = pwdata;
    assign access     = psel && penable;
    assign hit_desc   = (paddr == `ASP_CSR_DESC);
    assign hit_ctrl   = (paddr == `ASP_CSR_CTRL);
    assign hit_status = (paddr == `ASP_CSR_STATUS);
    assign wr_desc    = access && pwrite && hit_desc;
    assign wr_ctrl    = access && pwrite && hit_ctrl;

    // No wait states
    assign pready  = access;
    // Unknown offset, or status is read only
    assign pslverr = access && (!(hit_desc || hit_ctrl || hit_status) || (pwrite && hit_status));

    // Launch only from idle with a real length
    assign start = wr_ctrl && wr_word.ctrl.start && !busy && (length != '0);

    // Readback of the latched descriptor
    assign desc_word = {src_addr, dst_addr, length};

    always_comb begin
        prdata = '0;
        if (hit_desc) begin
            prdata = desc_word;
        end else if (hit_status) begin
            prdata = {32'b0, done_cnt, 14'b0, error, busy};
        end
    end

    // ====================================================================
    // Registers
    // ====================================================================
    always_ff @(posedge pclk) begin
        if (rst) begin
            src_addr <= '0;
            dst_addr <= '0;
            length   <= '0;
            busy     <= 1'b0;
            error    <= 1'b0;
            done_cnt <= '0;
            job_done <= 1'b0;
        end else begin
            // Completion seen one cycle after the last write is accepted
            job_done <= done;
            if (wr_desc) begin
                src_addr <= wr_word.desc.src;
                dst_addr <= wr_word.desc.dst;
                length   <= wr_word.desc.len;
            end
            if (done) begin
                busy     <= 1'b0;
                done_cnt <= done_cnt + 1'b1;
            end
            // Clear first so a rejected start in the same write still flags
            if (wr_ctrl && wr_word.ctrl.clr) begin
                error    <= 1'b0;
                done_cnt <= '0;
            end
            if (start) begin
                busy <= 1'b1;
            end else if (wr_ctrl && wr_word.ctrl.start) begin
                error <= 1'b1;
            end
        end
    end

    // A launch leaves the block busy, and never twice in a row
    a_start_once: assert property (@(posedge pclk) disable iff (rst)
        start |=> busy && !start)
        else $error("start issued while a job was running");

    // Writer completion only belongs to a running job
    a_done_busy: assert property (@(posedge pclk) disable iff (rst)
        done |-> busy)
        else $error("done arrived with no job running");

endmodule

// ==== logic/mmio_csr_pkg.sv ====
// MMIO register types for the copy shell
// The write word is decoded as a descriptor or as a control word by offset
`include "asp_settings.svh"

package mmio_csr_pkg;

    // Job length in words
    typedef logic [`ASP_LEN_W-1:0] csr_len_t;

    // Completed jobs since the last clear, status bits 31:16
    typedef logic [15:0] done_cnt_t;

    // Descriptor view, source in the top bits
    typedef struct packed {
        logic [`ASP_HOST_ADDR_W-1:0] src;
        logic [`ASP_LMEM_ADDR_W-1:0] dst;
        csr_len_t                    len;
    } desc_view_t;

    // Control view, only the two low bits act
    typedef struct packed {
        logic [`ASP_DATA_W-3:0] rsvd;
        logic                   clr;
        logic                   start;
    } ctrl_view_t;

    // One APB word, two meanings
    typedef union packed {
        desc_view_t desc;
        ctrl_view_t ctrl;
    } csr_word_u;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build the copy shell testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module asp_top_tb -o asp_top_tb
status=$?
if [ $status -ne 0 ]; then
    echo "FAIL: Verilator build returned status $status"
    exit 1
fi

out=$(./obj_dir/asp_top_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "FAIL: simulation returned status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "^No errors$"; then
    echo "PASS"
    exit 0
fi
echo "FAIL: pass line not found in simulation output"
exit 1

// ==== verilog.f ====
+incdir+include
logic/mmio_csr_pkg.sv
logic/mem_chan_pkg.sv
logic/beat_if.sv
logic/mmio_csr_block.sv
logic/host_read_engine.sv
logic/beat_fifo.sv
logic/local_mem_writer.sv
logic/asp_top.sv
dv/asp_top_tb.sv
